// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_eeprom_ctrl -f tb.f

out=$(./obj_dir/Vtb_eeprom_ctrl)
echo "$out"

grep -qx "RESULT: PASS" <<< "$out"

// File: src/eeprom_bus_engine.sv
`timescale 1ns/100ps
`default_nettype none
`include "eeprom_config.svh"

module eeprom_bus_engine (
    input  wire logic       CLK,
    input  wire logic       RESET,
    eeprom_cmd_if.engine    cmd,
    eeprom_sample_if.engine smp,
    output logic            scl,
    output logic            sda_out,
    output logic            sda_oe,
    input  wire logic       sda_in
);
    import eeprom_pkg::*;

    localparam int DIV = `EEPROM_CLK_DIV;

    // ST_START also serves as the repeated start of a read
    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_CTRL_W,
        ST_ADDR,
        ST_WDATA,
        ST_CTRL_R,
        ST_RDATA,
        ST_STOP
    } state_e;

    state_e      state;
    logic [15:0] div_cnt;
    logic        tick;
    logic [1:0]  q;         // quarter within the bit slot
    logic [3:0]  bitcnt;    // 8 is the ack or nack slot
    byte_t       tx_byte;
    byte_t       ctrl_byte;
    logic        rd_phase;  // past the dummy write of a read
    logic        byte_out;
    logic        scl_d;
    logic        sda_d;
    logic        oe_d;
    logic        cond_state;

    assign tick       = (div_cnt == 16'(DIV - 1));
    assign byte_out   = (state == ST_CTRL_W) || (state == ST_ADDR) ||
                        (state == ST_WDATA) || (state == ST_CTRL_R);
    assign ctrl_byte  = {`EEPROM_DEV_CODE, cmd.addr[`EEPROM_ADDR_W-1 -: 3], rd_phase};
    assign cond_state = (state == ST_START) || (state == ST_STOP);

    always_ff @(posedge CLK)
    begin
        if (RESET || state == ST_IDLE)
            div_cnt <= '0;
        else if (tick)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 16'd1;
    end

    // bus levels for the current quarter
    always_comb
    begin
        scl_d = 1'b1;
        sda_d = 1'b1;
        oe_d  = 1'b0;
        case (state)
            ST_START:
            begin
                scl_d = (q == 2'd1) || (q == 2'd2);
                sda_d = (q == 2'd0) || (q == 2'd1);  // falls with scl high
                oe_d  = 1'b1;
            end
            ST_CTRL_W, ST_ADDR, ST_WDATA, ST_CTRL_R:
            begin
                scl_d = (q == 2'd1) || (q == 2'd2);
                sda_d = (bitcnt == 4'd8) ? 1'b1 : tx_byte[7];
                oe_d  = (bitcnt != 4'd8);  // released for device ack
            end
            ST_RDATA:
            begin
                scl_d = (q == 2'd1) || (q == 2'd2);
                oe_d  = (bitcnt == 4'd8);  // master nack drives 1
            end
            ST_STOP:
            begin
                scl_d = (q != 2'd0);
                sda_d = (q >= 2'd2);  // rises with scl high
                oe_d  = (q != 2'd3);
            end
            default:
            begin
                scl_d = 1'b1;
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl     <= 1'b1;
            sda_out <= 1'b1;
            sda_oe  <= 1'b0;
        end
        else
        begin
            scl     <= scl_d;
            sda_out <= sda_d;
            sda_oe  <= oe_d;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= ST_IDLE;
            q          <= 2'd0;
            bitcnt     <= 4'd0;
            rd_phase   <= 1'b0;
            cmd.done   <= 1'b0;
            smp.sample <= 1'b0;
        end
        else
        begin
            cmd.done   <= 1'b0;
            smp.sample <= 1'b0;
            if (state == ST_IDLE)
            begin
                q      <= 2'd0;
                bitcnt <= 4'd0;
                if (cmd.start)
                begin
                    state    <= ST_START;
                    rd_phase <= 1'b0;
                end
            end
            else if (tick)
            begin
                q <= q + 2'd1;
                // scl high midpoint
                if (q == 2'd2 && ((byte_out && bitcnt == 4'd8) ||
                                  (state == ST_RDATA && bitcnt != 4'd8)))
                    smp.sample <= 1'b1;
                if (q == 2'd3)
                begin
                    if (state == ST_STOP)
                    begin
                        state    <= ST_IDLE;
                        cmd.done <= 1'b1;
                    end
                    else if (state == ST_START)
                        state <= rd_phase ? ST_CTRL_R : ST_CTRL_W;
                    else if (bitcnt != 4'd8)
                        bitcnt <= bitcnt + 4'd1;
                    else
                    begin
                        bitcnt <= 4'd0;
                        if (smp.abort)
                            state <= ST_STOP;  // no ack from the device
                        else
                        begin
                            case (state)
                                ST_CTRL_W:
                                    state <= ST_ADDR;
                                ST_ADDR:
                                    if (cmd.op == OP_READ)
                                    begin
                                        state    <= ST_START;
                                        rd_phase <= 1'b1;
                                    end
                                    else
                                        state <= ST_WDATA;
                                ST_CTRL_R:
                                    state <= ST_RDATA;
                                default:
                                    state <= ST_STOP;  // after write data or the nack
                            endcase
                        end
                    end
                end
            end
        end
    end

    // shifter, loaded at slot ends
    always_ff @(posedge CLK)
    begin
        if (state != ST_IDLE && tick && q == 2'd3)
        begin
            if (state == ST_START)
                tx_byte <= ctrl_byte;
            else if (bitcnt != 4'd8)
                tx_byte <= {tx_byte[6:0], 1'b0};
            else if (state == ST_CTRL_W)
                tx_byte <= cmd.addr[7:0];
            else
                tx_byte <= cmd.wdata;  // only sent after the address byte
        end
    end

    always_ff @(posedge CLK)
    begin
        if (tick && q == 2'd2)
        begin
            smp.kind    <= (state == ST_RDATA) ? SMP_DATA : SMP_ACK;
            smp.bit_val <= sda_in;
        end
    end

    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && sda_out != $past(sda_out)) |-> $past(cond_state));

    // a new command only reaches an idle engine
    a_start_idle: assert property (@(posedge CLK) disable iff (RESET)
        cmd.start |-> (state == ST_IDLE));

endmodule

`default_nettype wire

// File: src/eeprom_cmd_if.sv
`timescale 1ns/100ps
`default_nettype none

interface eeprom_cmd_if;
    import eeprom_pkg::*;

    logic  start;  // one cycle, fields valid
    op_e   op;
    addr_t addr;
    byte_t wdata;
    logic  done;   // one cycle after stop

    modport decode (
        output start,
        output op,
        output addr,
        output wdata,
        input  done
    );

    modport engine (
        input  start,
        input  op,
        input  addr,
        input  wdata,
        output done
    );

endinterface

`default_nettype wire

// File: src/eeprom_config.svh
`ifndef EEPROM_CONFIG_SVH
`define EEPROM_CONFIG_SVH

// CLK cycles per SCL quarter, 4 quarters per bit slot
`define EEPROM_CLK_DIV 1

// 2 KB array, bits 10..8 go out in the control byte
`define EEPROM_ADDR_W 11

`define EEPROM_DEV_CODE 4'b1010

`endif

// File: src/eeprom_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "eeprom_config.svh"

module eeprom_ctrl_top (
    input  wire logic                      CLK,
    input  wire logic                      RESET,
    input  wire logic                      req,
    input  wire logic                      we,
    input  wire logic [`EEPROM_ADDR_W-1:0] addr,
    input  wire eeprom_pkg::byte_t         wdata,
    output logic                           ack,
    output eeprom_pkg::byte_t              rdata,
    output logic                           err,
    output logic                           scl,
    output logic                           sda_out,
    output logic                           sda_oe,
    input  wire logic                      sda_in
);

    eeprom_cmd_if    cmd ();
    eeprom_sample_if smp ();

    eeprom_req_decode u_decode (
        .CLK   (CLK),
        .RESET (RESET),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .cmd   (cmd.decode)
    );

    eeprom_bus_engine u_engine (
        .CLK     (CLK),
        .RESET   (RESET),
        .cmd     (cmd.engine),
        .smp     (smp.engine),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe),
        .sda_in  (sda_in)
    );

    // err clears as each new transfer starts
    eeprom_read_result u_result (
        .CLK        (CLK),
        .RESET      (RESET),
        .smp        (smp.result),
        .start_seen (cmd.start),
        .rdata      (rdata),
        .err        (err)
    );

endmodule

`default_nettype wire

// File: src/eeprom_pkg.sv
`default_nettype none
`include "eeprom_config.svh"

package eeprom_pkg;

    typedef logic [`EEPROM_ADDR_W-1:0] addr_t;
    typedef logic [7:0] byte_t;

    typedef enum logic {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } op_e;

    // what the engine sampled at an scl high midpoint
    typedef enum logic [1:0] {
        SMP_ACK  = 2'd0,  // device ack slot
        SMP_DATA = 2'd1   // read data bit
    } sample_kind_e;

endpackage

`default_nettype wire

// File: src/eeprom_read_result.sv
`timescale 1ns/100ps
`default_nettype none

module eeprom_read_result (
    input  wire logic       CLK,
    input  wire logic       RESET,
    eeprom_sample_if.result smp,
    input  wire logic       start_seen,
    output eeprom_pkg::byte_t rdata,
    output logic            err
);
    import eeprom_pkg::*;

    logic [6:0] shreg;  // first seven bits, msb first
    logic [3:0] nbits;

    // nack from the device ends the transfer
    assign smp.abort = smp.sample && (smp.kind == SMP_ACK) && smp.bit_val;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            nbits <= 4'd0;
            err   <= 1'b0;
            rdata <= '0;
        end
        else if (start_seen)
        begin
            nbits <= 4'd0;
            err   <= 1'b0;
        end
        else if (smp.sample)
        begin
            if (smp.kind == SMP_ACK)
                err <= smp.bit_val;
            else
            begin
                nbits <= nbits + 4'd1;
                if (nbits == 4'd7)
                    rdata <= {shreg, smp.bit_val};  // eighth bit
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (smp.sample && smp.kind == SMP_DATA)
            shreg <= {shreg[5:0], smp.bit_val};
    end

    a_max_bits: assert property (@(posedge CLK) disable iff (RESET)
        (smp.sample && smp.kind == SMP_DATA) |-> (nbits < 4'd8));

endmodule

`default_nettype wire

// File: src/eeprom_req_decode.sv
`timescale 1ns/100ps
`default_nettype none

module eeprom_req_decode (
    input  wire logic              CLK,
    input  wire logic              RESET,
    input  wire logic              req,
    input  wire logic              we,
    input  wire eeprom_pkg::addr_t addr,
    input  wire eeprom_pkg::byte_t wdata,
    output logic                   ack,
    eeprom_cmd_if.decode           cmd
);
    import eeprom_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_ACK
    } state_e;

    state_e state;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= ST_IDLE;
            ack       <= 1'b0;
            cmd.start <= 1'b0;
        end
        else
        begin
            cmd.start <= 1'b0;
            case (state)
                ST_IDLE:
                    if (req)
                    begin
                        cmd.start <= 1'b1;
                        state     <= ST_BUSY;
                    end
                ST_BUSY:
                    if (cmd.done)
                    begin
                        ack   <= 1'b1;  // rdata and err settle with done
                        state <= ST_ACK;
                    end
                ST_ACK:
                    if (!req)  // return to zero
                    begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // command fields, held until the next request
    always_ff @(posedge CLK)
    begin
        if (state == ST_IDLE && req)
        begin
            cmd.op    <= we ? OP_WRITE : OP_READ;
            cmd.addr  <= addr;
            cmd.wdata <= wdata;
        end
    end

    // one transfer in flight
    a_done_busy: assert property (@(posedge CLK) disable iff (RESET)
        cmd.done |-> (state == ST_BUSY));

endmodule

`default_nettype wire

// File: src/eeprom_sample_if.sv
`timescale 1ns/100ps
`default_nettype none

interface eeprom_sample_if;
    import eeprom_pkg::*;

    logic         sample;
    sample_kind_e kind;
    logic         bit_val;
    logic         abort;  // same cycle as a failed ack sample

    modport engine (
        output sample,
        output kind,
        output bit_val,
        input  abort
    );

    modport result (
        input  sample,
        input  kind,
        input  bit_val,
        output abort
    );

endinterface

`default_nettype wire

// File: tb.f
+incdir+src
src/eeprom_pkg.sv
src/eeprom_cmd_if.sv
src/eeprom_sample_if.sv
src/eeprom_req_decode.sv
src/eeprom_bus_engine.sv
src/eeprom_read_result.sv
src/eeprom_ctrl_top.sv
verification/eeprom_model.sv
verification/tb_eeprom_ctrl.sv

// File: verification/eeprom_model.sv
`timescale 1ns/100ps
`default_nettype none
`include "eeprom_config.svh"

module eeprom_model (
    input  wire logic CLK,
    input  wire logic RESET,
    input  wire logic scl,
    input  wire logic sda,
    input  wire logic silent,     // withhold every ack
    output logic      sda_drive,  // open drain, 1 releases the line
    output int        write_count
);
    import eeprom_pkg::*;

    localparam int MEM_SIZE = 1 << `EEPROM_ADDR_W;

    typedef enum logic [2:0] {
        M_IDLE,
        M_RX,
        M_ACK,
        M_TX,
        M_MACK
    } mstate_e;

    byte_t      mem [0:MEM_SIZE-1];
    mstate_e    state;
    logic       scl_q;
    logic       sda_q;
    logic [3:0] bitcnt;
    byte_t      shreg;
    byte_t      tx_byte;
    logic [1:0] byte_idx;  // control, word address, data
    logic [2:0] block;
    byte_t      word;
    logic       rd;
    logic       start_cond;
    logic       stop_cond;
    logic       scl_rise;
    logic       scl_fall;

    // bus events, one CLK late
    assign start_cond = scl_q && scl && sda_q && !sda;
    assign stop_cond  = scl_q && scl && !sda_q && sda;
    assign scl_rise   = !scl_q && scl;
    assign scl_fall   = scl_q && !scl;

    initial
    begin
        for (int i = 0; i < MEM_SIZE; i++)
            mem[i] = 8'hFF;  // erased
    end

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            state       <= M_IDLE;
            sda_drive   <= 1'b1;
            write_count <= 0;
            bitcnt      <= 4'd0;
            byte_idx    <= 2'd0;
            rd          <= 1'b0;
        end
        else if (start_cond)
        begin
            state     <= M_RX;  // also the repeated start
            bitcnt    <= 4'd0;
            byte_idx  <= 2'd0;
            sda_drive <= 1'b1;
        end
        else if (stop_cond)
        begin
            state     <= M_IDLE;
            sda_drive <= 1'b1;
        end
        else if (scl_rise)
        begin
            case (state)
                M_RX:
                begin
                    shreg  <= {shreg[6:0], sda};
                    bitcnt <= bitcnt + 4'd1;
                end
                M_TX:
                    bitcnt <= bitcnt + 4'd1;
                M_MACK:
                    state <= M_IDLE;  // single byte reads only
                default:
                    state <= state;
            endcase
        end
        else if (scl_fall)
        begin
            case (state)
                M_RX:
                    if (bitcnt == 4'd8)
                    begin
                        state     <= M_ACK;
                        sda_drive <= 1'b0;
                        byte_idx  <= byte_idx + 2'd1;
                        case (byte_idx)
                            2'd0:
                                if (silent || shreg[7:4] != `EEPROM_DEV_CODE)
                                begin
                                    state     <= M_IDLE;
                                    sda_drive <= 1'b1;
                                end
                                else
                                begin
                                    block <= shreg[3:1];
                                    rd    <= shreg[0];
                                end
                            2'd1:
                                word <= shreg;
                            2'd2:
                            begin
                                mem[{block, word}] <= shreg;
                                write_count        <= write_count + 1;
                            end
                            default:
                            begin
                                state     <= M_IDLE;  // no page writes
                                sda_drive <= 1'b1;
                            end
                        endcase
                    end
                M_ACK:
                begin
                    bitcnt <= 4'd0;
                    if (rd)
                    begin
                        tx_byte   <= mem[{block, word}];
                        sda_drive <= mem[{block, word}][7];
                        state     <= M_TX;
                    end
                    else
                    begin
                        sda_drive <= 1'b1;
                        state     <= M_RX;
                    end
                end
                M_TX:
                    if (bitcnt == 4'd8)
                    begin
                        sda_drive <= 1'b1;  // master ack slot
                        state     <= M_MACK;
                    end
                    else
                        sda_drive <= tx_byte[3'd7 - bitcnt[2:0]];
                default:
                    state <= state;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_eeprom_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "eeprom_config.svh"

module tb_eeprom_ctrl;
    import eeprom_pkg::*;

    localparam int     N_REQ       = 87;
    localparam int     READ_CYCLES = (39 + 3) * 4 * `EEPROM_CLK_DIV + 10;  // plus handshake
    localparam longint WATCHDOG_NS = longint'(N_REQ) * READ_CYCLES * 2 * 100;

    logic  CLK;
    logic  RESET;
    logic  req;
    logic  we;
    addr_t addr;
    byte_t wdata;
    logic  ack;
    byte_t rdata;
    logic  err;
    logic  scl;
    logic  sda_out;
    logic  sda_oe;
    logic  sda_model;
    logic  silent;
    wire   sda_bus;
    int    model_writes;

    byte_t  ref_mem [addr_t];
    int     ref_writes = 0;
    logic   exp_read   = 1'b0;
    byte_t  exp_rdata  = 8'h00;
    logic   exp_err    = 1'b0;
    logic   ack_q      = 1'b0;
    int     n_req      = 0;
    int     n_ack      = 0;
    int     byte_errs  = 0;
    int     err_errs   = 0;
    int     bit_errs   = 0;
    int     count_errs = 0;
    integer seed       = 32'hdea27133;

    // wired-AND with pullup
    assign sda_bus = (sda_oe ? sda_out : 1'b1) & sda_model;

    eeprom_ctrl_top UUT (
        .CLK     (CLK),
        .RESET   (RESET),
        .req     (req),
        .we      (we),
        .addr    (addr),
        .wdata   (wdata),
        .ack     (ack),
        .rdata   (rdata),
        .err     (err),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe),
        .sda_in  (sda_bus)
    );

    eeprom_model u_model (
        .CLK         (CLK),
        .RESET       (RESET),
        .scl         (scl),
        .sda         (sda_bus),
        .silent      (silent),
        .sda_drive   (sda_model),
        .write_count (model_writes)
    );

    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // expected memory, unwritten bytes read as erased
    function automatic byte_t ref_access(op_e op, addr_t a, byte_t d);
        if (op == OP_WRITE)
        begin
            ref_mem[a] = d;
            ref_writes++;
            return d;
        end
        if (ref_mem.exists(a))
            return ref_mem[a];
        return 8'hFF;
    endfunction

    task automatic check_byte(byte_t got, byte_t exp, string what);
        if (got !== exp)
        begin
            byte_errs++;
            $display("FAILED at %0t ns: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_err(logic got, logic exp, string what);
        if (got !== exp)
        begin
            err_errs++;
            $display("FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp)
        begin
            bit_errs++;
            $display("FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // one four-phase request, req held for extra cycles after ack
    task automatic transfer(op_e op, addr_t a, byte_t d, logic quiet, int hold);
        exp_read = (op == OP_READ) && !quiet;
        exp_err  = quiet;
        if (!quiet)
            exp_rdata = ref_access(op, a, d);
        @(posedge CLK);
        req   <= 1'b1;
        we    <= (op == OP_WRITE);
        addr  <= a;
        wdata <= d;
        n_req++;
        @(posedge CLK);
        while (!ack)
            @(posedge CLK);
        repeat (hold)
        begin
            @(posedge CLK);
            check_bit(ack, 1'b1, "ack while req held");
            check_bit(scl, 1'b1, "scl idle while req held");
            check_bit(sda_oe, 1'b0, "sda released while req held");
        end
        req <= 1'b0;
        @(posedge CLK);
        while (ack)
            @(posedge CLK);
    endtask

    // compare at each ack rise
    always @(posedge CLK)
    begin
        ack_q <= ack;
        if (!RESET && ack && !ack_q)
        begin
            n_ack++;
            check_bit(req, 1'b1, "req at ack rise");
            check_err(err, exp_err, "err flag");
            if (exp_read)
                check_byte(rdata, exp_rdata, "read data");
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: transfers did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin
        logic [31:0] r;
        addr_t       a1;
        addr_t       a2;
        logic [2:0]  off;
        int          total;

        RESET  = 1'b1;
        req    = 1'b0;
        we     = 1'b0;
        addr   = '0;
        wdata  = '0;
        silent = 1'b0;
        repeat (8)
            @(posedge CLK);
        RESET <= 1'b0;
        repeat (2)
            @(posedge CLK);

        // idle bus before any request
        check_bit(ack, 1'b0, "ack after reset");
        check_bit(scl, 1'b1, "scl after reset");
        check_bit(sda_oe, 1'b0, "sda_oe after reset");
        check_err(err, 1'b0, "err after reset");
        check_byte(rdata, 8'h00, "rdata after reset");

        transfer(OP_READ, 11'h5C3, 8'h00, 1'b0, 0);  // never written
        transfer(OP_WRITE, 11'h2A7, 8'h3C, 1'b0, 0);
        transfer(OP_READ, 11'h2A7, 8'h00, 1'b0, 0);

        // no device ack, memory must stay as it was
        @(posedge CLK);
        silent <= 1'b1;
        transfer(OP_WRITE, 11'h2A7, 8'hC3, 1'b1, 0);
        @(posedge CLK);
        silent <= 1'b0;
        transfer(OP_READ, 11'h2A7, 8'h00, 1'b0, 0);

        transfer(OP_WRITE, 11'h0F1, 8'hA5, 1'b0, 6);  // slow req release
        transfer(OP_READ, 11'h0F1, 8'h00, 1'b0, 6);

        for (int i = 0; i < 20; i++)
        begin
            r   = $random(seed);
            a1  = r[10:0];
            off = (r[13:11] == 3'd0) ? 3'd5 : r[13:11];
            a2  = {a1[10:8] ^ off, a1[7:0]};  // same word, other block
            transfer(OP_WRITE, a1, r[21:14], 1'b0, int'(r[31:30]));
            transfer(OP_WRITE, a2, r[29:22], 1'b0, 0);
            transfer(OP_READ, a1, 8'h00, 1'b0, 0);
            transfer(OP_READ, a2, 8'h00, 1'b0, int'(r[31:30]));
        end

        repeat (4)
            @(posedge CLK);
        if (model_writes != ref_writes)
        begin
            count_errs++;
            $display("FAILED at %0t ns: model wrote %0d bytes, reference %0d",
                     $time, model_writes, ref_writes);
        end
        if (n_ack != n_req)
        begin
            count_errs++;
            $display("FAILED at %0t ns: %0d acks for %0d requests", $time, n_ack, n_req);
        end
        total = byte_errs + err_errs + bit_errs + count_errs;
        $display("errors: data %0d, err flag %0d, level %0d, count %0d",
                 byte_errs, err_errs, bit_errs, count_errs);
        if (total == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
